// File: common/sdram_defines.svh
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// Mode register fields, CAS latency and log2 of the read burst length
`define SDRAM_CAS 3'd2
`define SDRAM_BURST 3'd2

// Timing limits in SDRAM clocks
`define SDRAM_TRC 8
`define SDRAM_TRAS 6
`define SDRAM_TRP 2
`define SDRAM_TRCD 2
`define SDRAM_TDPL 2
`define SDRAM_TMRD 2

// Power-up wait, short for simulation (13300 on the board)
`define SDRAM_TINIT 200

// Auto-refresh period
`define SDRAM_TREFC 1039

// Drain before refresh, largest of tRAS, burst length and tDPL
`define SDRAM_TWAIT 6

`endif

// File: common/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

	// Commands as seen on CS/RAS/CAS/WE
	typedef enum logic [3:0] {
		NOP,
		BST,
		READ,
		WRITE,
		ACT,
		PRE,
		PALL,
		REF,
		MRS
	} sdram_cmd_t;

	typedef struct packed {
		logic [1:0] ba;
		logic [12:0] row;
		logic [8:0] column;
	} sdram_loc_t;

	// Word address, either linear or split into bank, row and column
	typedef union packed {
		logic [23:0] linear;
		sdram_loc_t loc;
	} sdram_addr_u;

	typedef struct packed {
		logic we;
		sdram_addr_u addr;
		logic [15:0] data;
	} sdram_req_t;

	typedef struct packed {
		sdram_addr_u addr;
		logic [15:0] data;
	} sdram_rsp_t;

	typedef struct packed {
		logic cke;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [1:0] ba;
		logic [12:0] addr;
		logic [1:0] dqm;
	} sdram_pins_t;

endpackage

`default_nettype wire

// File: sdram/sdram_bank.sv
`default_nettype none
`include "sdram_defines.svh"

module sdram_bank (
	input logic clk,
	input logic n_reset,
	input logic phase,
	input logic sel,
	input sdram_pkg::sdram_cmd_t cmd,
	input logic [12:0] row,
	output logic active,
	output logic match,
	output logic pre_ok,
	output logic act_ok,
	output logic rw_ok
);

	logic [12:0] open_row;
	logic [3:0] ras_cnt;
	logic [3:0] rc_cnt;
	logic [3:0] rp_cnt;
	logic [3:0] rcd_cnt;
	// Write recovery, also covers a read burst still running
	logic [3:0] dpl_cnt;

	function automatic logic [3:0] count_down(input logic [3:0] cnt);
		count_down = (cnt == 4'd0) ? 4'd0 : cnt - 4'd1;
	endfunction

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			active <= 1'b0;
			ras_cnt <= 4'd0;
			rc_cnt <= 4'd0;
			rp_cnt <= 4'd0;
			rcd_cnt <= 4'd0;
			dpl_cnt <= 4'd0;
		end else if (phase) begin
			ras_cnt <= count_down(ras_cnt);
			rc_cnt <= count_down(rc_cnt);
			rp_cnt <= count_down(rp_cnt);
			rcd_cnt <= count_down(rcd_cnt);
			dpl_cnt <= count_down(dpl_cnt);
			if (sel) begin
				case (cmd)
					sdram_pkg::ACT: begin
						active <= 1'b1;
						ras_cnt <= 4'(`SDRAM_TRAS - 1);
						rc_cnt <= 4'(`SDRAM_TRC - 1);
						rcd_cnt <= 4'(`SDRAM_TRCD - 1);
					end
					sdram_pkg::PRE, sdram_pkg::PALL: begin
						active <= 1'b0;
						rp_cnt <= 4'(`SDRAM_TRP - 1);
					end
					sdram_pkg::READ: dpl_cnt <= 4'((1 << `SDRAM_BURST) - 1);
					sdram_pkg::WRITE: dpl_cnt <= 4'(`SDRAM_TDPL - 1);
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase && sel && cmd == sdram_pkg::ACT)
			open_row <= row;
	end

	assign match = open_row == row;
	assign pre_ok = ras_cnt == 4'd0 && dpl_cnt == 4'd0;
	assign act_ok = !active && rp_cnt == 4'd0 && rc_cnt == 4'd0;
	assign rw_ok = active && rcd_cnt == 4'd0;

endmodule

`default_nettype wire

// File: sdram/sdram_ctrl.sv
`default_nettype none
`include "sdram_defines.svh"

module sdram_ctrl (
	input logic clk,
	input logic n_reset,
	input logic en,
	input logic req,
	input sdram_pkg::sdram_req_t req_data,
	output logic rdy,
	output sdram_pkg::sdram_rsp_t rsp,
	output logic rsp_valid,
	output sdram_pkg::sdram_pins_t pins,
	output logic dram_clk,
	inout wire [15:0] dq
);

	localparam int CAS = int'(`SDRAM_CAS);
	localparam int BW = int'(`SDRAM_BURST);
	localparam int BL = 1 << BW;
	localparam int RD_LEN = CAS + BL - 1;

	typedef enum logic [2:0] {
		ST_RESET, ST_INIT, ST_INIT_PALL, ST_PRECHARGE, ST_REFRESH, ST_EXECUTE, ST_ACTIVE
	} state_t;

	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_REGISTERED, SEQ_PRECHARGE, SEQ_ACTIVATE, SEQ_EXECUTE
	} seq_t;

	logic phase;
	state_t state, state_next;
	seq_t seq;
	logic [15:0] cnt, cnt_load;
	logic mode_pending;
	sdram_pkg::sdram_req_t cur;
	logic [1:0] ba;
	sdram_pkg::sdram_cmd_t tcmd, seq_cmd, cmd_next;
	logic [3:0] sel, active, match, pre_ok, act_ok, rw_ok;
	logic [3:0] wr_delay;
	logic [RD_LEN-1:0] rd_sr;
	logic capture, burst_start;
	sdram_pkg::sdram_addr_u addr_pipe [CAS];
	sdram_pkg::sdram_pins_t pins_next;
	logic dq_oe;
	logic [15:0] dq_out;

	// All SDRAM-rate state moves on edges where phase is high, DRAM_CLK falls there
	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			phase <= 1'b0;
		else
			phase <= ~phase;
	end
	assign dram_clk = phase;

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			state <= ST_RESET;
			cnt <= 16'd0;
			mode_pending <= 1'b1;
		end else if (phase) begin
			if (cnt == 16'd0) begin
				state <= state_next;
				cnt <= cnt_load;
			end else begin
				cnt <= cnt - 16'd1;
			end
			if (cmd_next == sdram_pkg::MRS)
				mode_pending <= 1'b0;
		end
	end

	always_comb begin
		state_next = state;
		cnt_load = 16'd0;
		tcmd = sdram_pkg::NOP;
		case (state)
			ST_RESET: begin
				state_next = ST_INIT;
				cnt_load = 16'(`SDRAM_TINIT - 1);
			end
			ST_INIT: begin
				state_next = ST_INIT_PALL;
				cnt_load = 16'(`SDRAM_TRP - 1);
				tcmd = sdram_pkg::PALL;
			end
			ST_INIT_PALL: begin
				state_next = ST_PRECHARGE;
				cnt_load = 16'(`SDRAM_TRC - 1);
				tcmd = sdram_pkg::REF;
			end
			ST_PRECHARGE: begin
				state_next = ST_REFRESH;
				cnt_load = 16'(`SDRAM_TRC - 1);
				tcmd = sdram_pkg::REF;
			end
			ST_REFRESH: begin
				if (mode_pending) begin
					cnt_load = 16'(`SDRAM_TMRD - 1);
					tcmd = sdram_pkg::MRS;
				end else begin
					// Period stays within tREFC, including the one with the MRS
					state_next = ST_EXECUTE;
					cnt_load = 16'(`SDRAM_TREFC - `SDRAM_TRC - `SDRAM_TMRD - `SDRAM_TWAIT
						- `SDRAM_TRP - 1);
				end
			end
			ST_EXECUTE: begin
				state_next = ST_ACTIVE;
				cnt_load = 16'(`SDRAM_TWAIT - 1);
			end
			ST_ACTIVE: begin
				state_next = ST_PRECHARGE;
				cnt_load = 16'(`SDRAM_TRP - 1);
				tcmd = sdram_pkg::PALL;
			end
			default: ;
		endcase
	end

	always_comb begin
		if (cnt == 16'd0 && tcmd != sdram_pkg::NOP)
			cmd_next = tcmd;
		else if (state == ST_EXECUTE)
			cmd_next = seq_cmd;
		else
			cmd_next = sdram_pkg::NOP;
	end

	assign rdy = seq == SEQ_IDLE;
	assign ba = cur.addr.loc.ba;

	always_ff @(posedge clk) begin
		if (req && rdy)
			cur <= req_data;
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			seq <= SEQ_IDLE;
		end else if (req && rdy) begin
			seq <= SEQ_REGISTERED;
		end else if (phase && seq != SEQ_IDLE) begin
			// Refresh closes every bank, so decide again afterwards
			if (state != ST_EXECUTE) begin
				seq <= SEQ_REGISTERED;
			end else begin
				case (seq)
					SEQ_REGISTERED: begin
						if (!active[ba])
							seq <= SEQ_ACTIVATE;
						else if (!match[ba])
							seq <= SEQ_PRECHARGE;
						else
							seq <= SEQ_EXECUTE;
					end
					SEQ_PRECHARGE: if (cmd_next == sdram_pkg::PRE) seq <= SEQ_ACTIVATE;
					SEQ_ACTIVATE: if (cmd_next == sdram_pkg::ACT) seq <= SEQ_EXECUTE;
					SEQ_EXECUTE: begin
						if (cmd_next == sdram_pkg::READ || cmd_next == sdram_pkg::WRITE)
							seq <= SEQ_IDLE;
					end
					default: seq <= SEQ_IDLE;
				endcase
			end
		end
	end

	always_comb begin
		seq_cmd = sdram_pkg::NOP;
		case (seq)
			SEQ_PRECHARGE: if (pre_ok[ba]) seq_cmd = sdram_pkg::PRE;
			SEQ_ACTIVATE: if (act_ok[ba]) seq_cmd = sdram_pkg::ACT;
			SEQ_EXECUTE: begin
				if (rw_ok[ba]) begin
					if (cur.we) begin
						if (wr_delay == 4'd0)
							seq_cmd = sdram_pkg::WRITE;
					end else if (wr_delay <= 4'(CAS + 1)) begin
						seq_cmd = sdram_pkg::READ;
					end
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		for (int i = 0; i < 4; i++)
			sel[i] = ba == 2'(i) || cmd_next == sdram_pkg::PALL;
	end

	for (genvar i = 0; i < 4; i++) begin : g_bank
		sdram_bank u_bank (
			.clk(clk),
			.n_reset(n_reset),
			.phase(phase),
			.sel(sel[i]),
			.cmd(cmd_next),
			.row(cur.addr.loc.row),
			.active(active[i]),
			.match(match[i]),
			.pre_ok(pre_ok[i]),
			.act_ok(act_ok[i]),
			.rw_ok(rw_ok[i])
		);
	end

	// Reads wait out the previous burst, writes wait until read data left DQ
	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			wr_delay <= 4'd0;
		end else if (phase) begin
			if (cmd_next == sdram_pkg::READ)
				wr_delay <= 4'(CAS + BL);
			else if (wr_delay != 4'd0)
				wr_delay <= wr_delay - 4'd1;
		end
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			rd_sr <= '0;
		else if (phase)
			rd_sr <= {rd_sr[RD_LEN-2:0], cmd_next == sdram_pkg::READ};
	end

	always_ff @(posedge clk) begin
		if (phase) begin
			addr_pipe[0] <= cur.addr;
			for (int i = 1; i < CAS; i++)
				addr_pipe[i] <= addr_pipe[i-1];
		end
	end

	// Word k is taken on the falling DRAM_CLK edge CAS+k clocks after READ
	assign burst_start = rd_sr[CAS-1];
	assign capture = |rd_sr[CAS-1 +: BL];

	always_ff @(posedge clk) begin
		if (phase && capture) begin
			rsp.data <= dq;
			if (burst_start)
				rsp.addr <= addr_pipe[CAS-1];
			else
				rsp.addr.linear[BW-1:0] <= rsp.addr.linear[BW-1:0] + BW'(1);
		end
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= phase && capture;
	end

	always_comb begin
		pins_next = '0;
		pins_next.cke = 1'b1;
		pins_next.cs_n = ~en;
		pins_next.ras_n = 1'b1;
		pins_next.cas_n = 1'b1;
		pins_next.we_n = 1'b1;
		case (cmd_next)
			sdram_pkg::BST: pins_next.we_n = 1'b0;
			sdram_pkg::READ, sdram_pkg::WRITE: begin
				pins_next.cas_n = 1'b0;
				pins_next.we_n = cmd_next != sdram_pkg::WRITE;
				pins_next.ba = ba;
				pins_next.addr[8:0] = cur.addr.loc.column;
			end
			sdram_pkg::ACT: begin
				pins_next.ras_n = 1'b0;
				pins_next.ba = ba;
				pins_next.addr = cur.addr.loc.row;
			end
			sdram_pkg::PRE, sdram_pkg::PALL: begin
				pins_next.ras_n = 1'b0;
				pins_next.we_n = 1'b0;
				pins_next.ba = ba;
				pins_next.addr[10] = cmd_next == sdram_pkg::PALL;
			end
			sdram_pkg::REF: begin
				pins_next.ras_n = 1'b0;
				pins_next.cas_n = 1'b0;
			end
			sdram_pkg::MRS: begin
				pins_next.ras_n = 1'b0;
				pins_next.cas_n = 1'b0;
				pins_next.we_n = 1'b0;
				// Single-word write, CAS latency, sequential burst
				{pins_next.ba, pins_next.addr} = {5'b00000, 1'b1, 2'b00, `SDRAM_CAS, 1'b0,
					`SDRAM_BURST};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk, negedge n_reset) begin
		if (!n_reset) begin
			pins <= '{cke: 1'b0, cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
				ba: 2'b00, addr: 13'h0, dqm: 2'b00};
			dq_oe <= 1'b0;
		end else if (phase) begin
			pins <= pins_next;
			dq_oe <= cmd_next == sdram_pkg::WRITE;
		end
	end

	always_ff @(posedge clk) begin
		if (phase)
			dq_out <= cur.data;
	end

	assign dq = dq_oe ? dq_out : 16'bz;

endmodule

`default_nettype wire

// File: verilog/sdram_top.sv
`default_nettype none

module sdram_top (
	input logic clk,
	input logic n_reset,
	input logic en,
	input logic req,
	input sdram_pkg::sdram_req_t req_data,
	output logic rdy,
	output sdram_pkg::sdram_rsp_t rsp,
	output logic rsp_valid,
	output sdram_pkg::sdram_pins_t dram_pins,
	output logic dram_clk,
	inout wire [15:0] dram_dq
);

	sdram_ctrl u_ctrl (
		.clk(clk),
		.n_reset(n_reset),
		.en(en),
		.req(req),
		.req_data(req_data),
		.rdy(rdy),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.pins(dram_pins),
		.dram_clk(dram_clk),
		.dq(dram_dq)
	);

endmodule

`default_nettype wire

// File: tb/sdram_model.sv
`default_nettype none
`include "sdram_defines.svh"

module sdram_model (
	input wire dram_clk,
	input sdram_pkg::sdram_pins_t pins,
	inout wire [15:0] dq
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam int LOG_SIZE = 4096;
	localparam int CAS = int'(`SDRAM_CAS);
	localparam int BL = 1 << `SDRAM_BURST;

	logic [15:0] mem [logic [23:0]];
	logic bank_open [4] = '{default: 1'b0};
	logic [12:0] open_row [4] = '{default: 13'h0};
	int tick = 0;
	int log_count = 0;
	sdram_pkg::sdram_cmd_t log_cmd [LOG_SIZE];
	int log_tick [LOG_SIZE];
	logic [1:0] log_ba [LOG_SIZE];
	logic [12:0] log_addr [LOG_SIZE];
	// Scheduled read words, in the order they go out
	int out_tick [$];
	logic [15:0] out_data [$];
	logic dq_en = 1'b0;
	logic [15:0] dq_val = 16'h0;
	sdram_pkg::sdram_cmd_t cmd;

	assign dq = dq_en ? dq_val : 16'bz;

	// Unwritten words hold a pattern of their own address
	function automatic logic [15:0] read_word(input logic [23:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr[15:0] ^ 16'hA5A5;
	endfunction

	always_comb begin
		cmd = sdram_pkg::NOP;
		if (pins.cke && !pins.cs_n) begin
			case ({pins.ras_n, pins.cas_n, pins.we_n})
				3'b110: cmd = sdram_pkg::BST;
				3'b101: cmd = sdram_pkg::READ;
				3'b100: cmd = sdram_pkg::WRITE;
				3'b011: cmd = sdram_pkg::ACT;
				3'b010: cmd = pins.addr[10] ? sdram_pkg::PALL : sdram_pkg::PRE;
				3'b001: cmd = sdram_pkg::REF;
				3'b000: cmd = sdram_pkg::MRS;
				default: ;
			endcase
		end
	end

	always @(posedge dram_clk) begin
		logic [23:0] a;
		if (cmd != sdram_pkg::NOP && log_count < LOG_SIZE) begin
			log_cmd[log_count] = cmd;
			log_tick[log_count] = tick;
			log_ba[log_count] = pins.ba;
			log_addr[log_count] = pins.addr;
			log_count++;
		end
		a = {pins.ba, open_row[pins.ba], pins.addr[8:0]};
		case (cmd)
			sdram_pkg::ACT: begin
				bank_open[pins.ba] = 1'b1;
				open_row[pins.ba] = pins.addr;
			end
			sdram_pkg::PRE: bank_open[pins.ba] = 1'b0;
			sdram_pkg::PALL: begin
				for (int b = 0; b < 4; b++)
					bank_open[b] = 1'b0;
			end
			sdram_pkg::WRITE: mem[a] = dq;
			sdram_pkg::READ: begin
				// Word k valid after edge CAS-1+k, sequential wrap in the burst
				for (int k = 0; k < BL; k++) begin
					out_tick.push_back(tick + CAS - 1 + k);
					out_data.push_back(read_word({a[23:2], 2'(a[1:0] + 2'(k))}));
				end
			end
			default: ;
		endcase
		dq_en = 1'b0;
		if (out_tick.size() > 0 && out_tick[0] == tick) begin
			dq_en = 1'b1;
			dq_val = out_data.pop_front();
			void'(out_tick.pop_front());
		end
		tick++;
	end

endmodule

`default_nettype wire

// File: tb/tb_sdram.sv
`default_nettype none
`include "sdram_defines.svh"

module tb_sdram;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int N_RANDOM = 200;
	localparam int N_REQUESTS = N_RANDOM + 12;
	localparam int T_SDRAM = 80;
	localparam int WATCHDOG_NS = (`SDRAM_TINIT + N_REQUESTS * 64) * T_SDRAM;
	localparam int BL = 1 << `SDRAM_BURST;

	logic clk = 1'b0;
	logic n_reset = 1'b0;
	logic en = 1'b1;
	logic req = 1'b0;
	sdram_pkg::sdram_req_t req_data = '0;
	logic rdy;
	sdram_pkg::sdram_rsp_t rsp;
	logic rsp_valid;
	sdram_pkg::sdram_pins_t dram_pins;
	logic dram_clk;
	wire [15:0] dram_dq;

	logic [15:0] ref_mem [logic [23:0]];
	sdram_pkg::sdram_rsp_t got [$];
	logic [31:0] rng = 32'h90bf;
	int checks = 0;
	int errors = 0;
	int mark_checks = 0;
	int mark_errors = 0;
	int misses = 0;

	always #20 clk = ~clk;

	sdram_top UUT (
		.clk(clk),
		.n_reset(n_reset),
		.en(en),
		.req(req),
		.req_data(req_data),
		.rdy(rdy),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.dram_pins(dram_pins),
		.dram_clk(dram_clk),
		.dram_dq(dram_dq)
	);

	sdram_model chip (
		.dram_clk(dram_clk),
		.pins(dram_pins),
		.dq(dram_dq)
	);

	always @(negedge clk) begin
		if (rsp_valid)
			got.push_back(rsp);
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Few banks and rows, so hits and misses both show up
	function automatic logic [23:0] pick_address(input logic [31:0] r);
		logic [12:0] row;
		case (r[3:2])
			2'd0: row = 13'h0000;
			2'd1: row = 13'h0a5c;
			default: row = 13'h1f03;
		endcase
		return {r[1:0], row, 5'b0, r[7:4]};
	endfunction

	function automatic logic [15:0] ref_read(input logic [23:0] addr);
		if (ref_mem.exists(addr))
			return ref_mem[addr];
		return addr[15:0] ^ 16'hA5A5;
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Check failed at %0t ns: %s", $time, what);
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	task automatic send_request(input logic we, input logic [23:0] addr,
			input logic [15:0] data);
		@(negedge clk);
		req = 1'b1;
		req_data.we = we;
		req_data.addr.linear = addr;
		req_data.data = data;
		while (!rdy)
			@(negedge clk);
		@(negedge clk);
		req = 1'b0;
		// Back high once READ or WRITE went out
		while (!rdy)
			@(negedge clk);
	endtask

	task automatic write_word(input logic [23:0] addr, input logic [15:0] data);
		send_request(1'b1, addr, data);
		ref_mem[addr] = data;
	endtask

	// The bank must be closed by PRE or PALL before the ACT of the new row
	task automatic check_row_change(input int first_cmd, input logic [1:0] b,
			input logic [12:0] row);
		logic closed;
		logic seen;
		closed = 1'b0;
		seen = 1'b0;
		for (int i = first_cmd; i < chip.log_count; i++) begin
			if (chip.log_cmd[i] == sdram_pkg::PALL
					|| (chip.log_cmd[i] == sdram_pkg::PRE && chip.log_ba[i] == b))
				closed = 1'b1;
			else if (chip.log_cmd[i] == sdram_pkg::ACT && chip.log_ba[i] == b)
				seen = closed && chip.log_addr[i] == row;
		end
		check_true(seen, $sformatf("bank %0d was not precharged and opened at row %h", b, row));
	endtask

	task automatic read_and_check(input logic [23:0] addr);
		logic [23:0] exp_addr;
		int first_cmd;
		logic miss;
		first_cmd = chip.log_count;
		miss = chip.bank_open[addr[23:22]] && chip.open_row[addr[23:22]] != addr[21:9];
		got.delete();
		send_request(1'b0, addr, 16'h0);
		while (got.size() < BL)
			@(negedge clk);
		// Room for a stray extra word
		repeat (8) @(negedge clk);
		check_value("read word count", 32'(got.size()), 32'(BL));
		for (int k = 0; k < BL && k < got.size(); k++) begin
			exp_addr = {addr[23:2], 2'(addr[1:0] + 2'(k))};
			check_value("response address", 32'(got[k].addr.linear), 32'(exp_addr));
			check_value("response data", 32'(got[k].data), 32'(ref_read(exp_addr)));
		end
		if (miss) begin
			misses++;
			check_row_change(first_cmd, addr[23:22], addr[21:9]);
		end
	endtask

	task automatic check_refresh();
		int last;
		int refs;
		last = -1;
		refs = 0;
		check_true(chip.log_count < 4096, "command log overflowed");
		for (int i = 0; i < chip.log_count; i++) begin
			if (chip.log_cmd[i] == sdram_pkg::REF) begin
				refs++;
				if (last >= 0)
					check_true(chip.log_tick[i] - last <= `SDRAM_TREFC,
						$sformatf("REF at clock %0d came too late", chip.log_tick[i]));
				// The second power-up REF follows the first one directly
				if (refs != 2)
					check_true(i > 0 && chip.log_cmd[i - 1] == sdram_pkg::PALL,
						$sformatf("REF at clock %0d has no PALL before it", chip.log_tick[i]));
				last = chip.log_tick[i];
			end
		end
		check_true(refs >= 3, "too few REF commands in the run");
		check_true(chip.tick - last <= `SDRAM_TREFC, "no REF in the last refresh period");
	endtask

	initial begin
		logic [31:0] r;
		logic [23:0] a;
		int miss_mark;

		repeat (5) @(negedge clk);
		check_value("cke during reset", 32'(dram_pins.cke), 32'd0);
		check_value("ras_n during reset", 32'(dram_pins.ras_n), 32'd1);
		check_value("cas_n during reset", 32'(dram_pins.cas_n), 32'd1);
		check_value("we_n during reset", 32'(dram_pins.we_n), 32'd1);
		check_value("dqm during reset", 32'(dram_pins.dqm), 32'd0);
		check_value("rsp_valid during reset", 32'(rsp_valid), 32'd0);
		check_value("rdy during reset", 32'(rdy), 32'd1);
		n_reset = 1'b1;
		while (chip.log_count < 4)
			@(negedge clk);
		check_value("1st command", 32'(chip.log_cmd[0]), 32'(sdram_pkg::PALL));
		check_value("2nd command", 32'(chip.log_cmd[1]), 32'(sdram_pkg::REF));
		check_value("3rd command", 32'(chip.log_cmd[2]), 32'(sdram_pkg::REF));
		check_value("4th command", 32'(chip.log_cmd[3]), 32'(sdram_pkg::MRS));
		// Single write at bit 9, CAS at 6:4, sequential, burst length at 2:0
		check_value("mode word", 32'({chip.log_ba[3], chip.log_addr[3]}),
			32'((1 << 9) | (int'(`SDRAM_CAS) << 4) | int'(`SDRAM_BURST)));
		check_value("dqm after power-up", 32'(dram_pins.dqm), 32'd0);
		end_test("power_up");

		r = next_random();
		a = pick_address(r);
		write_word(a, r[31:16]);
		read_and_check(a);
		end_test("write_read");

		for (int k = 0; k < 4; k++) begin
			r = next_random();
			a = pick_address(r);
			a[1:0] = 2'(k);
			read_and_check(a);
		end
		end_test("burst_order");

		miss_mark = misses;
		write_word({2'd2, 13'h0123, 9'h011}, 16'h5aa5);
		for (int k = 0; k < 4; k++)
			read_and_check({2'd2, k[0] ? 13'h0123 : 13'h0456, 9'h011});
		check_true(misses > miss_mark, "no row miss happened in the row miss test");
		end_test("row_miss");

		for (int n = 0; n < N_RANDOM; n++) begin
			r = next_random();
			a = pick_address(r);
			if (r[8])
				write_word(a, r[31:16]);
			else
				read_and_check(a);
		end
		end_test("random_mix");

		check_refresh();
		end_test("refresh");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/sdram_pkg.sv
sdram/sdram_bank.sv
sdram/sdram_ctrl.sv
verilog/sdram_top.sv
tb/sdram_model.sv
tb/tb_sdram.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP ?= tb_sdram
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
